// ==== common/clr_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// head of the clear queue, popped by take
interface clr_req_if;

   logic                                       avail;
   logic [line_mem_pkg::GROUP_ADDR_BITS-1:0]   group;
   logic [line_mem_pkg::GROUP_BITS-1:0]        mask;
   logic                                       take;

   // queue presents the head entry
   modport queue (
      output avail,
      output group,
      output mask,
      input  take
   );

   // tracker consumes it
   modport tracker (
      input  avail,
      input  group,
      input  mask,
      output take
   );

endinterface

`default_nettype wire

// ==== common/line_mem_pkg.sv ====
`default_nettype none

package line_mem_pkg;

   // ------------------------------------------------------------------------
   // memory geometry
   // ------------------------------------------------------------------------

   // 64 lines of 64 bytes
   localparam int LINE_COUNT     = 64;
   localparam int WORDS_PER_LINE = 8;

   // one 64-bit word per access, one mask bit per byte
   localparam int WORD_BYTES     = 8;
   localparam int WORD_BITS      = 64;
   localparam int WORD_ADDR_BITS = 9;

   // ------------------------------------------------------------------------
   // valid bits
   // ------------------------------------------------------------------------

   // valid ram word, one bit per line
   localparam int GROUP_BITS         = 32;
   localparam int GROUP_COUNT        = 2;
   localparam int GROUP_ADDR_BITS    = 1;
   localparam int LINE_IN_GROUP_BITS = 5;

   // pending clear requests
   localparam int CLR_QUEUE_DEPTH = 4;

   // update op carried through the valid rmw pipeline
   typedef enum logic [1:0] {
      VOP_NONE,
      VOP_SET,
      VOP_CLEAR,
      VOP_INIT
   } vld_op_t;

endpackage

`default_nettype wire

// ==== common/mem_wr_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// word write into the line memory, no back-pressure
interface mem_wr_if;

   logic                                      en;
   logic [line_mem_pkg::WORD_ADDR_BITS-1:0]   addr;
   logic [line_mem_pkg::WORD_BITS-1:0]        data;
   logic [line_mem_pkg::WORD_BYTES-1:0]       mask;

   // driving side
   modport src (
      output en,
      output addr,
      output data,
      output mask
   );

   // data memory and valid tracker both watch the writes
   modport snk (
      input en,
      input addr,
      input data,
      input mask
   );

endinterface

`default_nettype wire

// ==== flist.f ====
common/line_mem_pkg.sv
common/mem_wr_if.sv
common/clr_req_if.sv
hdl/clr_queue.sv
valid_tracker/valid_tracker.sv
hdl/byte_lane_mem.sv
hdl/line_mem_top.sv
verification/tb_line_mem.sv

// ==== hdl/byte_lane_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_lane_mem (
   input  logic                                      wr_clk,
   mem_wr_if.snk                                     wr,
   input  logic                                      rd_en,
   input  logic [line_mem_pkg::WORD_ADDR_BITS-1:0]   rd_addr,
   output logic [line_mem_pkg::WORD_BITS-1:0]        rd_data
);

   // -------------------------------------------------------------------------
   // one byte-wide ram per mask bit
   // -------------------------------------------------------------------------

   genvar i;

   generate
      for (i = 0; i < line_mem_pkg::WORD_BYTES; i++) begin : g_lane

         // 512 entries, one byte of every word
         logic [7:0] lane_ram [line_mem_pkg::LINE_COUNT * line_mem_pkg::WORDS_PER_LINE];
         logic [7:0] lane_q;

         // byte written only under its own mask bit
         always_ff @(posedge wr_clk) begin
            if (wr.en && wr.mask[i]) begin
               lane_ram[wr.addr] <= wr.data[8*i +: 8];
            end
         end

         // registered read, old data on a same-edge write
         always_ff @(posedge wr_clk) begin
            if (rd_en) begin
               lane_q <= lane_ram[rd_addr];
            end
         end

         assign rd_data[8*i +: 8] = lane_q;

      end
   endgenerate

endmodule

`default_nettype wire

// ==== hdl/clr_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module clr_queue (
   input  logic                                       wr_clk,
   input  logic                                       rst,
   input  logic                                       clr_en,
   input  logic [line_mem_pkg::GROUP_ADDR_BITS-1:0]   clr_group,
   input  logic [line_mem_pkg::GROUP_BITS-1:0]        clr_mask,
   output logic                                       clr_stall,
   clr_req_if.queue                                   q
);

   // entry storage
   logic [line_mem_pkg::GROUP_ADDR_BITS-1:0] grp_mem  [line_mem_pkg::CLR_QUEUE_DEPTH];
   logic [line_mem_pkg::GROUP_BITS-1:0]      mask_mem [line_mem_pkg::CLR_QUEUE_DEPTH];

   logic [$clog2(line_mem_pkg::CLR_QUEUE_DEPTH)-1:0]   wr_ptr;
   logic [$clog2(line_mem_pkg::CLR_QUEUE_DEPTH)-1:0]   rd_ptr;
   logic [$clog2(line_mem_pkg::CLR_QUEUE_DEPTH+1)-1:0] count;

   logic push;
   logic pop;

   assign clr_stall = int'(count) == line_mem_pkg::CLR_QUEUE_DEPTH;
   assign q.avail   = count != '0;
   assign q.group   = grp_mem[rd_ptr];
   assign q.mask    = mask_mem[rd_ptr];

   // stalled producer holds its request
   assign push = clr_en && !clr_stall;
   assign pop  = q.take && q.avail;

   always_ff @(posedge wr_clk) begin
      if (push) begin
         grp_mem[wr_ptr]  <= clr_group;
         mask_mem[wr_ptr] <= clr_mask;
      end
   end

   // pointers wrap on their own, depth is a power of two
   always_ff @(posedge wr_clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== hdl/line_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_mem_top (
   input  logic                                      wr_clk,
   input  logic                                      rst,

   // word write port
   input  logic                                      wr_en,
   input  logic [line_mem_pkg::WORD_ADDR_BITS-1:0]   wr_addr,
   input  logic [line_mem_pkg::WORD_BITS-1:0]        wr_data,
   input  logic [line_mem_pkg::WORD_BYTES-1:0]       wr_mask,

   // word read port, one cycle latency
   input  logic                                      rd_en,
   input  logic [line_mem_pkg::WORD_ADDR_BITS-1:0]   rd_addr,
   output logic [line_mem_pkg::WORD_BITS-1:0]        rd_data,
   output logic                                      rd_line_valid,

   // valid clear requests
   input  logic                                      clr_en,
   input  logic [line_mem_pkg::GROUP_ADDR_BITS-1:0]  clr_group,
   input  logic [line_mem_pkg::GROUP_BITS-1:0]       clr_mask,
   output logic                                      clr_stall,

   output logic                                      init_done
);

   mem_wr_if  wr_bus ();
   clr_req_if clr_bus ();

   // -------------------------------------------------------------------------
   // write port onto the shared bus
   // -------------------------------------------------------------------------

   assign wr_bus.en   = wr_en;
   assign wr_bus.addr = wr_addr;
   assign wr_bus.data = wr_data;
   assign wr_bus.mask = wr_mask;

   // -------------------------------------------------------------------------
   // blocks
   // -------------------------------------------------------------------------

   clr_queue i_clr_queue (
      .wr_clk    (wr_clk),
      .rst       (rst),
      .clr_en    (clr_en),
      .clr_group (clr_group),
      .clr_mask  (clr_mask),
      .clr_stall (clr_stall),
      .q         (clr_bus)
   );

   valid_tracker i_valid_tracker (
      .wr_clk        (wr_clk),
      .rst           (rst),
      .wr            (wr_bus),
      .q             (clr_bus),
      .rd_en         (rd_en),
      .rd_addr       (rd_addr),
      .rd_line_valid (rd_line_valid),
      .init_done     (init_done)
   );

   // data storage, no reset
   byte_lane_mem i_byte_lane_mem (
      .wr_clk  (wr_clk),
      .wr      (wr_bus),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the line memory testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -j 0 -f flist.f --top-module tb_line_mem \
   -Mdir obj_dir -o tb_line_mem
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_line_mem > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "test failed" "$log"; then
   echo "failure reported in $log"
   exit 1
fi
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi
echo "no failure found in $log"
exit 0

// ==== valid_tracker/valid_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module valid_tracker (
   input  logic                                      wr_clk,
   input  logic                                      rst,
   mem_wr_if.snk                                     wr,
   clr_req_if.tracker                                q,
   input  logic                                      rd_en,
   input  logic [line_mem_pkg::WORD_ADDR_BITS-1:0]   rd_addr,
   output logic                                      rd_line_valid,
   output logic                                      init_done
);

   // one 32-bit word of valid bits per group
   logic [line_mem_pkg::GROUP_BITS-1:0] vld_ram [line_mem_pkg::GROUP_COUNT];

   // write address split into group, line and word
   logic [line_mem_pkg::GROUP_ADDR_BITS-1:0]       wr_group;
   logic [line_mem_pkg::LINE_IN_GROUP_BITS-1:0]    wr_line;
   logic [$clog2(line_mem_pkg::WORDS_PER_LINE)-1:0] wr_word;
   logic [line_mem_pkg::GROUP_ADDR_BITS-1:0]       rd_group;
   logic [line_mem_pkg::LINE_IN_GROUP_BITS-1:0]    rd_line;

   // reset sweep
   logic [line_mem_pkg::GROUP_ADDR_BITS-1:0] sweep_grp;
   logic                                     sweep_issued;

   // stage READ
   logic                                     wr_set;
   line_mem_pkg::vld_op_t                    op_nxt;
   logic [line_mem_pkg::GROUP_ADDR_BITS-1:0] group_nxt;
   logic [line_mem_pkg::GROUP_BITS-1:0]      mask_nxt;

   // stage WRITE
   line_mem_pkg::vld_op_t                    ppl_op;
   logic [line_mem_pkg::GROUP_ADDR_BITS-1:0] ppl_group;
   logic [line_mem_pkg::GROUP_BITS-1:0]      ppl_mask;
   logic [line_mem_pkg::GROUP_BITS-1:0]      rmw_bits;
   logic [line_mem_pkg::GROUP_BITS-1:0]      vld_base;
   logic [line_mem_pkg::GROUP_BITS-1:0]      vld_next;

   // last group written and its value
   logic [line_mem_pkg::GROUP_ADDR_BITS-1:0] cache_group;
   logic [line_mem_pkg::GROUP_BITS-1:0]      cache_bits;

   assign {wr_group, wr_line, wr_word} = wr.addr;
   assign {rd_group, rd_line} = rd_addr[line_mem_pkg::WORD_ADDR_BITS-1 -:
                                        line_mem_pkg::GROUP_ADDR_BITS +
                                        line_mem_pkg::LINE_IN_GROUP_BITS];

   // -------------------------------------------------------------------------
   // stage READ, pick one update per cycle
   // -------------------------------------------------------------------------

   // top byte of the last word completes the line
   assign wr_set = sweep_issued && wr.en && wr.mask[line_mem_pkg::WORD_BYTES-1] &&
                   int'(wr_word) == line_mem_pkg::WORDS_PER_LINE - 1;

   // sets cannot wait, clears sit in the queue
   assign q.take = sweep_issued && !wr_set && q.avail;

   always_comb begin
      op_nxt    = line_mem_pkg::VOP_NONE;
      group_nxt = q.group;
      mask_nxt  = q.mask;
      if (!sweep_issued) begin
         op_nxt    = line_mem_pkg::VOP_INIT;
         group_nxt = sweep_grp;
         mask_nxt  = '0;
      end else if (wr_set) begin
         op_nxt    = line_mem_pkg::VOP_SET;
         group_nxt = wr_group;
         mask_nxt  = {{(line_mem_pkg::GROUP_BITS-1){1'b0}}, 1'b1} << wr_line;
      end else if (q.avail) begin
         op_nxt = line_mem_pkg::VOP_CLEAR;
      end
   end

   always_ff @(posedge wr_clk) begin
      if (rst) begin
         ppl_op <= line_mem_pkg::VOP_NONE;
      end else begin
         ppl_op <= op_nxt;
      end
   end

   always_ff @(posedge wr_clk) begin
      ppl_group <= group_nxt;
      ppl_mask  <= mask_nxt;
      rmw_bits  <= vld_ram[group_nxt];
   end

   // -------------------------------------------------------------------------
   // stage WRITE, merge and write back
   // -------------------------------------------------------------------------

   // ram read missed a write to the same group landing at that edge
   assign vld_base = (ppl_group == cache_group) ? cache_bits : rmw_bits;

   always_comb begin
      case (ppl_op)
         line_mem_pkg::VOP_SET:   vld_next = vld_base | ppl_mask;
         line_mem_pkg::VOP_CLEAR: vld_next = vld_base & ~ppl_mask;
         line_mem_pkg::VOP_INIT:  vld_next = '0;
         default:                 vld_next = vld_base;
      endcase
   end

   always_ff @(posedge wr_clk) begin
      if (ppl_op != line_mem_pkg::VOP_NONE) begin
         vld_ram[ppl_group] <= vld_next;
         cache_group        <= ppl_group;
         cache_bits         <= vld_next;
      end
   end

   // -------------------------------------------------------------------------
   // reset sweep and read port
   // -------------------------------------------------------------------------

   always_ff @(posedge wr_clk) begin
      if (rst) begin
         sweep_grp    <= '0;
         sweep_issued <= 1'b0;
         init_done    <= 1'b0;
      end else begin
         if (!sweep_issued) begin
            sweep_grp <= sweep_grp + 1'b1;
            if (int'(sweep_grp) == line_mem_pkg::GROUP_COUNT - 1) begin
               sweep_issued <= 1'b1;
            end
         end
         // done once the last group's zero lands
         if (ppl_op == line_mem_pkg::VOP_INIT &&
             int'(ppl_group) == line_mem_pkg::GROUP_COUNT - 1) begin
            init_done <= 1'b1;
         end
      end
   end

   always_ff @(posedge wr_clk) begin
      if (rst) begin
         rd_line_valid <= 1'b0;
      end else if (rd_en) begin
         rd_line_valid <= vld_ram[rd_group][rd_line];
      end
   end

endmodule

`default_nettype wire

// ==== verification/tb_line_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_line_mem;

   typedef enum logic [2:0] {OP_WR, OP_WR_RND, OP_RD, OP_IDLE, OP_CLR, OP_BURST} step_op_t;

   // table row with the idle cycle count kept in data
   typedef struct packed {
      step_op_t    op;
      logic [8:0]  addr;
      logic [63:0] data;
      logic [31:0] mask;
      logic [0:0]  group;
      logic        exp_vld;
   } step_t;

   logic        wr_clk;
   logic        rst;
   logic        wr_en;
   logic [8:0]  wr_addr;
   logic [63:0] wr_data;
   logic [7:0]  wr_mask;
   logic        rd_en;
   logic [8:0]  rd_addr;
   logic [63:0] rd_data;
   logic        rd_line_valid;
   logic        clr_en;
   logic [0:0]  clr_group;
   logic [31:0] clr_mask;
   logic        clr_stall;
   logic        init_done;

   // reference model that skips bytes never written
   logic [63:0] model_mem   [512];
   logic [7:0]  model_known [512];
   logic [63:0] model_valid;

   step_t       steps [$];
   string       step_name [$];
   logic [31:0] rng_state   = 32'hbeba_cad8;
   logic        table_ready = 1'b0;

   line_mem_top i_dut (.*);

   initial begin
      wr_clk = 1'b0;
      forever #4 wr_clk = ~wr_clk;
   end

   // -------------------------------------------------------------------------
   // helpers
   // -------------------------------------------------------------------------

   task automatic abort_run();
      $display("test failed");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                  input logic [63:0] act_val);
      $display("error %s: expected %h, actual %h", name, exp_val, act_val);
      abort_run();
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic next_word(output logic [63:0] w);
      rng_state = xorshift32(rng_state);
      w[63:32]  = rng_state;
      rng_state = xorshift32(rng_state);
      w[31:0]   = rng_state;
   endtask

   function automatic logic [8:0] word_addr(input int line, input int word);
      return 9'(line * line_mem_pkg::WORDS_PER_LINE + word);
   endfunction

   // byte mask widened to a bit mask
   function automatic logic [63:0] byte_bits(input logic [7:0] bmask);
      logic [63:0] bits;
      bits = '0;
      for (int b = 7; b >= 0; b--) begin
         bits = {bits[55:0], {8{bmask[3'(b)]}}};
      end
      return bits;
   endfunction

   // last word with its top byte completes the line
   task automatic model_write(input logic [8:0] addr, input logic [63:0] data,
                              input logic [7:0] mask);
      model_mem[addr]   = (model_mem[addr] & ~byte_bits(mask)) | (data & byte_bits(mask));
      model_known[addr] = model_known[addr] | mask;
      if (mask[7] && addr[2:0] == 3'd7) begin
         model_valid[addr[8:3]] = 1'b1;
      end
   endtask

   task automatic model_clear(input logic group, input logic [31:0] mask);
      if (group) begin
         model_valid[63:32] &= ~mask;
      end else begin
         model_valid[31:0] &= ~mask;
      end
   endtask

   // -------------------------------------------------------------------------
   // bus tasks that start and end on a falling edge
   // -------------------------------------------------------------------------

   task automatic drive_write(input logic [8:0] addr, input logic [63:0] data,
                              input logic [7:0] mask);
      wr_en   = 1'b1;
      wr_addr = addr;
      wr_data = data;
      wr_mask = mask;
      @(posedge wr_clk);
      @(negedge wr_clk);
      wr_en = 1'b0;
      model_write(addr, data, mask);
   endtask

   task automatic read_check(input string name, input logic [8:0] addr, input logic exp_vld);
      logic [63:0] km;
      logic [63:0] exp_data;
      rd_en   = 1'b1;
      rd_addr = addr;
      @(posedge wr_clk);
      @(negedge wr_clk);
      rd_en    = 1'b0;
      km       = byte_bits(model_known[addr]);
      exp_data = model_mem[addr] & km;
      assert ((rd_data & km) === exp_data)
         else report_mismatch({name, " data"}, exp_data, rd_data & km);
      assert (rd_line_valid === exp_vld)
         else report_mismatch({name, " valid"}, {63'b0, exp_vld}, {63'b0, rd_line_valid});
   endtask

   task automatic check_all_lines(input string name);
      for (int line = 0; line < 64; line++) begin
         read_check($sformatf("%s line %0d", name, line), word_addr(line, 0),
                    model_valid[6'(line)]);
      end
   endtask

   task automatic drive_clear(input string name, input logic group, input logic [31:0] mask);
      int waited;
      waited    = 0;
      clr_en    = 1'b1;
      clr_group = group;
      clr_mask  = mask;
      while (clr_stall) begin
         @(negedge wr_clk);
         waited++;
         if (waited > 20) begin
            $display("%s: clear request was never accepted", name);
            abort_run();
         end
      end
      @(posedge wr_clk);
      @(negedge wr_clk);
      clr_en = 1'b0;
      model_clear(group, mask);
   endtask

   // sets every cycle keep the queue from draining until it is full
   task automatic run_burst(input string name);
      logic [63:0] w;
      int          accepted;
      int          cyc;
      accepted  = 0;
      cyc       = 0;
      clr_en    = 1'b1;
      clr_group = 1'b0;
      clr_mask  = 32'h1 << 20;
      while (!clr_stall) begin
         if (cyc > 12) begin
            $display("%s: clr_stall never rose under back-to-back sets", name);
            abort_run();
         end
         next_word(w);
         drive_write(word_addr(48 + cyc, 7), w, 8'hff);
         model_clear(1'b0, clr_mask);
         accepted++;
         clr_mask = clr_mask << 1;
         cyc++;
      end
      assert (accepted == 4) else report_mismatch(name, 64'd4, 64'(accepted));
      // fifth request held while sets go on
      repeat (3) begin
         next_word(w);
         drive_write(word_addr(48 + cyc, 7), w, 8'hff);
         cyc++;
         assert (clr_stall) else begin
            $display("%s: clr_stall fell while sets were still arriving", name);
            abort_run();
         end
      end
      while (clr_stall) begin
         @(posedge wr_clk);
         @(negedge wr_clk);
         cyc++;
         if (cyc > 40) begin
            $display("%s: clr_stall stayed high after the writes stopped", name);
            abort_run();
         end
      end
      @(posedge wr_clk);
      @(negedge wr_clk);
      clr_en = 1'b0;
      model_clear(1'b0, clr_mask);
      repeat (12) @(negedge wr_clk);
      assert (!clr_stall) else begin
         $display("%s: clr_stall still high with the queue drained", name);
         abort_run();
      end
   endtask

   // -------------------------------------------------------------------------
   // stimulus table
   // -------------------------------------------------------------------------

   task automatic add_step(input string name, input step_op_t op, input logic [8:0] addr,
                           input logic [63:0] data, input logic [31:0] mask,
                           input logic group, input logic exp_vld);
      step_t st;
      st = '{op, addr, data, mask, group, exp_vld};
      steps.push_back(st);
      step_name.push_back(name);
   endtask

   task automatic build_table();
      string tn;
      tn = "masked write merge";
      add_step(tn, OP_WR_RND, word_addr(3, 2), 64'h0, 32'hff, 1'b0, 1'b0);
      add_step(tn, OP_WR_RND, word_addr(3, 2), 64'h0, 32'h5a, 1'b0, 1'b0);
      add_step(tn, OP_RD, word_addr(3, 2), 64'h0, 32'h0, 1'b0, 1'b0);
      add_step(tn, OP_WR_RND, word_addr(40, 5), 64'h0, 32'hff, 1'b0, 1'b0);
      add_step(tn, OP_WR_RND, word_addr(40, 5), 64'h0, 32'h0f, 1'b0, 1'b0);
      add_step(tn, OP_WR_RND, word_addr(40, 5), 64'h0, 32'hc0, 1'b0, 1'b0);
      add_step(tn, OP_RD, word_addr(40, 5), 64'h0, 32'h0, 1'b0, 1'b0);
      add_step(tn, OP_WR_RND, word_addr(17, 0), 64'h0, 32'hff, 1'b0, 1'b0);
      add_step(tn, OP_WR_RND, word_addr(17, 0), 64'h0, 32'h81, 1'b0, 1'b0);
      add_step(tn, OP_RD, word_addr(17, 0), 64'h0, 32'h0, 1'b0, 1'b0);
      add_step(tn, OP_WR_RND, word_addr(63, 6), 64'h0, 32'h3c, 1'b0, 1'b0);
      add_step(tn, OP_RD, word_addr(63, 6), 64'h0, 32'h0, 1'b0, 1'b0);
      tn = "set needs top byte";
      add_step(tn, OP_WR, word_addr(5, 7), 64'h55, 32'h7f, 1'b0, 1'b0);
      add_step(tn, OP_IDLE, 9'h0, 64'd6, 32'h0, 1'b0, 1'b0);
      add_step(tn, OP_RD, word_addr(5, 7), 64'h0, 32'h0, 1'b0, 1'b0);
      tn = "set needs last word";
      add_step(tn, OP_WR, word_addr(5, 3), 64'h1234, 32'hff, 1'b0, 1'b0);
      add_step(tn, OP_IDLE, 9'h0, 64'd6, 32'h0, 1'b0, 1'b0);
      add_step(tn, OP_RD, word_addr(5, 0), 64'h0, 32'h0, 1'b0, 1'b0);
      tn = "set on last byte";
      add_step(tn, OP_WR, word_addr(5, 7), 64'haa00_0000_0000_0000, 32'h80, 1'b0, 1'b0);
      add_step(tn, OP_IDLE, 9'h0, 64'd6, 32'h0, 1'b0, 1'b0);
      add_step(tn, OP_RD, word_addr(5, 2), 64'h0, 32'h0, 1'b0, 1'b1);
      tn = "back-to-back sets";
      add_step(tn, OP_WR, word_addr(8, 7), 64'h0808, 32'hff, 1'b0, 1'b0);
      add_step(tn, OP_WR, word_addr(9, 7), 64'h0909, 32'hff, 1'b0, 1'b0);
      add_step(tn, OP_WR, word_addr(10, 7), 64'h0a0a, 32'hff, 1'b0, 1'b0);
      add_step(tn, OP_IDLE, 9'h0, 64'd6, 32'h0, 1'b0, 1'b0);
      add_step(tn, OP_RD, word_addr(8, 7), 64'h0, 32'h0, 1'b0, 1'b1);
      add_step(tn, OP_RD, word_addr(9, 3), 64'h0, 32'h0, 1'b0, 1'b1);
      add_step(tn, OP_RD, word_addr(10, 7), 64'h0, 32'h0, 1'b0, 1'b1);
      tn = "clear selected bits";
      add_step(tn, OP_WR, word_addr(20, 7), 64'h2020, 32'hff, 1'b0, 1'b0);
      add_step(tn, OP_WR, word_addr(21, 7), 64'h2121, 32'hff, 1'b0, 1'b0);
      add_step(tn, OP_WR, word_addr(22, 7), 64'h2222, 32'hff, 1'b0, 1'b0);
      add_step(tn, OP_IDLE, 9'h0, 64'd6, 32'h0, 1'b0, 1'b0);
      // lines 5, 8 and 21
      add_step(tn, OP_CLR, 9'h0, 64'h0, 32'h0020_0120, 1'b0, 1'b0);
      add_step(tn, OP_IDLE, 9'h0, 64'd6, 32'h0, 1'b0, 1'b0);
      add_step(tn, OP_RD, word_addr(5, 7), 64'h0, 32'h0, 1'b0, 1'b0);
      add_step(tn, OP_RD, word_addr(8, 7), 64'h0, 32'h0, 1'b0, 1'b0);
      add_step(tn, OP_RD, word_addr(9, 7), 64'h0, 32'h0, 1'b0, 1'b1);
      add_step(tn, OP_RD, word_addr(20, 7), 64'h0, 32'h0, 1'b0, 1'b1);
      add_step(tn, OP_RD, word_addr(21, 7), 64'h0, 32'h0, 1'b0, 1'b0);
      add_step(tn, OP_RD, word_addr(22, 7), 64'h0, 32'h0, 1'b0, 1'b1);
      tn = "clear other group";
      add_step(tn, OP_WR, word_addr(40, 7), 64'h4000_0000_0000_0000, 32'h80, 1'b0, 1'b0);
      add_step(tn, OP_WR, word_addr(41, 7), 64'h4100_0000_0000_0000, 32'h80, 1'b0, 1'b0);
      add_step(tn, OP_IDLE, 9'h0, 64'd6, 32'h0, 1'b0, 1'b0);
      add_step(tn, OP_CLR, 9'h0, 64'h0, 32'h0000_0200, 1'b1, 1'b0);
      add_step(tn, OP_IDLE, 9'h0, 64'd6, 32'h0, 1'b0, 1'b0);
      add_step(tn, OP_RD, word_addr(40, 7), 64'h0, 32'h0, 1'b0, 1'b1);
      add_step(tn, OP_RD, word_addr(41, 7), 64'h0, 32'h0, 1'b0, 1'b0);
      add_step(tn, OP_RD, word_addr(9, 7), 64'h0, 32'h0, 1'b0, 1'b1);
      add_step("stall and drain", OP_BURST, 9'h0, 64'h0, 32'h0, 1'b0, 1'b0);
   endtask

   // -------------------------------------------------------------------------
   // main sequence and watchdog
   // -------------------------------------------------------------------------

   initial begin
      step_t       st;
      logic [63:0] w;
      int          waited;
      rst         = 1'b1;
      wr_en       = 1'b0;
      wr_addr     = '0;
      wr_data     = '0;
      wr_mask     = '0;
      rd_en       = 1'b0;
      rd_addr     = '0;
      clr_en      = 1'b0;
      clr_group   = '0;
      clr_mask    = '0;
      model_known = '{default: 8'h00};
      model_valid = '0;
      build_table();
      table_ready = 1'b1;
      repeat (10) @(posedge wr_clk);
      @(negedge wr_clk);
      assert (!clr_stall && !init_done && !rd_line_valid) else begin
         $display("clr_stall, init_done or rd_line_valid not low in reset");
         abort_run();
      end
      rst    = 1'b0;
      waited = 0;
      while (!init_done) begin
         @(negedge wr_clk);
         waited++;
         if (waited > 20) begin
            $display("init_done did not rise after reset");
            abort_run();
         end
      end
      check_all_lines("after reset");
      for (int i = 0; i < steps.size(); i++) begin
         st = steps[i];
         case (st.op)
            OP_WR:     drive_write(st.addr, st.data, st.mask[7:0]);
            OP_WR_RND: begin
               next_word(w);
               drive_write(st.addr, w, st.mask[7:0]);
            end
            OP_RD:     read_check(step_name[i], st.addr, st.exp_vld);
            OP_IDLE:   repeat (int'(st.data)) @(negedge wr_clk);
            OP_CLR:    drive_clear(step_name[i], st.group, st.mask);
            OP_BURST:  run_burst(step_name[i]);
            default:   ;
         endcase
      end
      check_all_lines("final state");
      $display("test passed");
      $finish;
   end

   // limit scales with the table
   initial begin
      int limit;
      wait (table_ready);
      limit = steps.size() * 20 + 200;
      repeat (limit) @(posedge wr_clk);
      $display("watchdog: simulation did not finish within %0d cycles", limit);
      abort_run();
   end

endmodule

`default_nettype wire
